//--- logic/gpio_reg_pkg.sv
`default_nettype none

// --------------------------------------------------
// APB register map of the GPIO block
// --------------------------------------------------
package gpio_reg_pkg;

   // bus widths
   localparam int APB_DATA_W = 32;
   localparam int APB_ADDR_W = 8;

   // one config word per pin lives below this address
   localparam logic [APB_ADDR_W-1:0] CFG_REGION_END = 8'h80;

   // interrupt status, reads status and write-one-to-clear
   localparam logic [APB_ADDR_W-1:0] ADDR_INTR = 8'h80;

   // gated input data, read only
   localparam logic [APB_ADDR_W-1:0] ADDR_GPIN = 8'h90;

   // output data register
   localparam logic [APB_ADDR_W-1:0] ADDR_GPOUT = 8'hA0;

   // --------------------------------------------------
   // bus types
   // --------------------------------------------------
   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;

endpackage

`default_nettype wire

//--- logic/gpio_cfg_pkg.sv
`default_nettype none

// --------------------------------------------------
// per-pin configuration byte layout
// --------------------------------------------------
package gpio_cfg_pkg;

   localparam int CFG_W = 8;

   // enable bits
   localparam int CFG_OUT_EN = 0;
   localparam int CFG_IN_EN  = 1;
   localparam int CFG_OE_EN  = 2;
   localparam int CFG_INT_EN = 3;

   // bit 4 is spare, stored and read back only

   // interrupt type occupies bits 7..5
   localparam int CFG_TYPE_LSB = 5;

   typedef logic [CFG_W-1:0] pin_cfg_t;

   // --------------------------------------------------
   // interrupt type field encoding
   // --------------------------------------------------
   // codes 5 and 6 are unassigned and behave like disabled
   typedef enum logic [2:0]
   {
      INT_LEVEL_HIGH = 3'd0,
      INT_LEVEL_LOW  = 3'd1,
      INT_EDGE_POS   = 3'd2,
      INT_EDGE_NEG   = 3'd3,
      INT_EDGE_BOTH  = 3'd4,
      INT_DISABLED   = 3'd7
   } int_type_e;

endpackage

`default_nettype wire

//--- logic/gpio_apb_decode.sv
`timescale 1ns/1ns
`default_nettype none

// APB write decode for the GPIO register file
module gpio_apb_decode
   import gpio_reg_pkg::*;
#(
   parameter int IO_NUM = 32
)
(
   input  wire logic             psel_i,
   input  wire logic             penable_i,
   input  wire logic             pwrite_i,
   input  wire apb_addr_t        paddr_i,
   input  wire apb_data_t        pwdata_i,

   output logic [IO_NUM-1:0]     cfg_we_o,
   output logic                  intr_clr_we_o,
   output logic                  gpout_we_o,
   output apb_data_t             wdata_o
);

   // word index of a config register
   localparam int WORD_W = APB_ADDR_W - 2;

   logic              wr_xfer;
   logic              in_cfg_region;
   logic [WORD_W-1:0] word_idx;

   // --------------------------------------------------
   // transfer qualification
   // --------------------------------------------------
   // access phase of a write, APB never waits here
   assign wr_xfer       = psel_i & penable_i & pwrite_i;
   assign in_cfg_region = (paddr_i < CFG_REGION_END);
   assign word_idx      = paddr_i[APB_ADDR_W-1:2];

   // --------------------------------------------------
   // strobes
   // --------------------------------------------------
   // one strobe per pin config word
   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         cfg_we_o[i] = wr_xfer && in_cfg_region && (word_idx == WORD_W'(i));
      end
   end

   // shared by all slices
   assign intr_clr_we_o = wr_xfer && (paddr_i == ADDR_INTR);
   assign gpout_we_o    = wr_xfer && (paddr_i == ADDR_GPOUT);

   // each slice picks its own bit
   assign wdata_o = pwdata_i;

endmodule

`default_nettype wire

//--- logic/gpio_pin_slice.sv
`timescale 1ns/1ns
`default_nettype none

// one GPIO pin: config, input sync, edge flags, interrupt and output bit
module gpio_pin_slice
   import gpio_reg_pkg::*;
   import gpio_cfg_pkg::*;
#(
   parameter int         PIN_IDX   = 0,
   parameter logic [0:0] RESET_OUT = 1'b0
)
(
   input  wire logic      PCLK,
   input  wire logic      aresetn,
   input  wire logic      gpio_in_i,
   input  wire logic      cfg_we_i,
   input  wire logic      intr_clr_we_i,
   input  wire logic      gpout_we_i,
   input  wire apb_data_t wdata_i,

   output pin_cfg_t       cfg_o,
   output logic           intr_stat_o,
   output logic           gpin_o,
   output logic           gpout_o,
   output logic           gpio_out_o,
   output logic           gpio_oe_o,
   output logic           int_o
);

   pin_cfg_t  cfg_q;
   int_type_e int_type;
   logic      sync1;
   logic      sync2;
   logic      sync3;
   logic      rise;
   logic      fall;
   logic      clr_bit;
   logic      edge_pos;
   logic      edge_neg;
   logic      edge_both;
   logic      int_sel;
   logic      int_live;
   logic      intr_stat_q;
   logic      gpout_q;

   // --------------------------------------------------
   // configuration byte
   // --------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         cfg_q <= '0;
      else if (cfg_we_i)
         cfg_q <= wdata_i[CFG_W-1:0];
   end

   // --------------------------------------------------
   // input synchroniser, sync3 is the pin value
   // --------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sync1 <= 1'b0;
         sync2 <= 1'b0;
         sync3 <= 1'b0;
      end
      else
      begin
         sync1 <= gpio_in_i;
         sync2 <= sync1;
         sync3 <= sync2;
      end
   end

   // edge seen one stage ahead of sync3
   assign rise    = sync2 & ~sync3;
   assign fall    = ~sync2 & sync3;
   assign clr_bit = intr_clr_we_i & wdata_i[PIN_IDX];

   // sticky flags, a new edge beats a clear
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos  <= 1'b0;
         edge_neg  <= 1'b0;
         edge_both <= 1'b0;
      end
      else if (!cfg_q[CFG_INT_EN])
      begin
         edge_pos  <= 1'b0;
         edge_neg  <= 1'b0;
         edge_both <= 1'b0;
      end
      else
      begin
         edge_pos  <= rise | (edge_pos & ~clr_bit);
         edge_neg  <= fall | (edge_neg & ~clr_bit);
         edge_both <= rise | fall | (edge_both & ~clr_bit);
      end
   end

   // --------------------------------------------------
   // interrupt selection
   // --------------------------------------------------
   assign int_type = int_type_e'(cfg_q[CFG_TYPE_LSB +: $bits(int_type_e)]);

   always_comb
   begin
      case (int_type)
         INT_LEVEL_HIGH: int_sel = sync3;
         INT_LEVEL_LOW:  int_sel = ~sync3;
         INT_EDGE_POS:   int_sel = edge_pos;
         INT_EDGE_NEG:   int_sel = edge_neg;
         INT_EDGE_BOTH:  int_sel = edge_both;
         INT_DISABLED:   int_sel = 1'b0;
         default:        int_sel = 1'b0;
      endcase
   end

   assign int_live = cfg_q[CFG_INT_EN] & int_sel;

   // status trails the live interrupt by one cycle
   // a write-one-to-clear zeroes it for that edge
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         intr_stat_q <= 1'b0;
      else
         intr_stat_q <= int_live & ~clr_bit;
   end

   // --------------------------------------------------
   // output data bit
   // --------------------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         gpout_q <= RESET_OUT;
      else if (gpout_we_i)
         gpout_q <= wdata_i[PIN_IDX];
   end

   assign cfg_o       = cfg_q;
   assign intr_stat_o = intr_stat_q;
   assign gpin_o      = cfg_q[CFG_IN_EN] & sync3;
   assign gpout_o     = gpout_q;
   assign gpio_out_o  = cfg_q[CFG_OUT_EN] & gpout_q;
   // driver only when the output path is enabled too
   assign gpio_oe_o   = cfg_q[CFG_OE_EN] & cfg_q[CFG_OUT_EN];
   assign int_o       = int_live;

endmodule

`default_nettype wire

//--- logic/gpio_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

// combinational APB read data for the GPIO registers
module gpio_read_mux
   import gpio_reg_pkg::*;
   import gpio_cfg_pkg::*;
#(
   parameter int IO_NUM = 32
)
(
   input  wire apb_addr_t                paddr_i,
   input  wire pin_cfg_t [IO_NUM-1:0]    cfg_i,
   input  wire logic [IO_NUM-1:0]        intr_stat_i,
   input  wire logic [IO_NUM-1:0]        gpin_i,
   input  wire logic [IO_NUM-1:0]        gpout_i,

   output apb_data_t                     prdata_o
);

   localparam int WORD_W = APB_ADDR_W - 2;

   logic [WORD_W-1:0] word_idx;

   assign word_idx = paddr_i[APB_ADDR_W-1:2];

   // --------------------------------------------------
   // address select
   // --------------------------------------------------
   // unmapped addresses and pins past IO_NUM read zero
   always_comb
   begin
      prdata_o = '0;
      if (paddr_i < CFG_REGION_END)
      begin
         for (int i = 0; i < IO_NUM; i++)
         begin
            if (word_idx == WORD_W'(i))
               prdata_o[CFG_W-1:0] = cfg_i[i];
         end
      end
      else if (paddr_i == ADDR_INTR)
         prdata_o[IO_NUM-1:0] = intr_stat_i;
      else if (paddr_i == ADDR_GPIN)
         prdata_o[IO_NUM-1:0] = gpin_i;
      else if (paddr_i == ADDR_GPOUT)
         prdata_o[IO_NUM-1:0] = gpout_i;
   end

endmodule

`default_nettype wire

//--- logic/gpio_top.sv
`timescale 1ns/1ns
`default_nettype none

// APB GPIO, register-controlled configuration per pin
module gpio_top
   import gpio_reg_pkg::*;
   import gpio_cfg_pkg::*;
#(
   parameter int                IO_NUM        = 32,
   parameter logic [IO_NUM-1:0] OUT_RESET_VAL = '0
)
(
   input  wire logic              PCLK,
   input  wire logic              aresetn,

   // APB slave
   input  wire logic              psel_i,
   input  wire logic              penable_i,
   input  wire logic              pwrite_i,
   input  wire apb_addr_t         paddr_i,
   input  wire apb_data_t         pwdata_i,
   output apb_data_t              prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,

   // pins and interrupts
   input  wire logic [IO_NUM-1:0] gpio_in_i,
   output logic [IO_NUM-1:0]      int_o,
   output logic                   int_or_o,
   output logic [IO_NUM-1:0]      gpio_out_o,
   output logic [IO_NUM-1:0]      gpio_oe_o
);

   logic [IO_NUM-1:0]     cfg_we;
   logic                  intr_clr_we;
   logic                  gpout_we;
   apb_data_t             wdata;
   pin_cfg_t [IO_NUM-1:0] cfg;
   logic [IO_NUM-1:0]     intr_stat;
   logic [IO_NUM-1:0]     gpin;
   logic [IO_NUM-1:0]     gpout;

   // zero wait states, no slave errors
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   gpio_apb_decode #(
      .IO_NUM        (IO_NUM)
   ) i_decode (
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .paddr_i       (paddr_i),
      .pwdata_i      (pwdata_i),
      .cfg_we_o      (cfg_we),
      .intr_clr_we_o (intr_clr_we),
      .gpout_we_o    (gpout_we),
      .wdata_o       (wdata)
   );

   // --------------------------------------------------
   // pin slices
   // --------------------------------------------------
   for (genvar i = 0; i < IO_NUM; i++)
   begin : g_pin
      gpio_pin_slice #(
         .PIN_IDX       (i),
         .RESET_OUT     (OUT_RESET_VAL[i])
      ) i_slice (
         .PCLK          (PCLK),
         .aresetn       (aresetn),
         .gpio_in_i     (gpio_in_i[i]),
         .cfg_we_i      (cfg_we[i]),
         .intr_clr_we_i (intr_clr_we),
         .gpout_we_i    (gpout_we),
         .wdata_i       (wdata),
         .cfg_o         (cfg[i]),
         .intr_stat_o   (intr_stat[i]),
         .gpin_o        (gpin[i]),
         .gpout_o       (gpout[i]),
         .gpio_out_o    (gpio_out_o[i]),
         .gpio_oe_o     (gpio_oe_o[i]),
         .int_o         (int_o[i])
      );
   end

   gpio_read_mux #(
      .IO_NUM      (IO_NUM)
   ) i_read_mux (
      .paddr_i     (paddr_i),
      .cfg_i       (cfg),
      .intr_stat_i (intr_stat),
      .gpin_i      (gpin),
      .gpout_i     (gpout),
      .prdata_o    (prdata_o)
   );

   // combined interrupt line
   assign int_or_o = |int_o;

endmodule

`default_nettype wire

//--- testbench/gpio_checker.sv
`timescale 1ns/1ns
`default_nettype none

// concurrent checks on the GPIO top level, bound into gpio_top
module gpio_checker
   import gpio_cfg_pkg::*;
#(
   parameter int IO_NUM = 8
)
(
   input wire logic                  PCLK,
   input wire logic                  aresetn,
   input wire logic [IO_NUM-1:0]     gpio_in_i,
   input wire logic [IO_NUM-1:0]     int_o,
   input wire logic                  int_or_o,
   input wire logic [IO_NUM-1:0]     gpio_out_o,
   input wire logic [IO_NUM-1:0]     gpio_oe_o,
   input wire logic [IO_NUM-1:0]     gpout,
   input wire pin_cfg_t [IO_NUM-1:0] cfg,
   input wire logic                  intr_clr_we,
   input wire logic [31:0]           wdata
);

   int fail_cnt = 0;

   // input history, in_dN holds gpio_in_i from N edges back
   logic [IO_NUM-1:0] in_d1;
   logic [IO_NUM-1:0] in_d2;
   logic [IO_NUM-1:0] in_d3;
   logic [IO_NUM-1:0] in_d4;

   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         in_d1 <= '0;
         in_d2 <= '0;
         in_d3 <= '0;
         in_d4 <= '0;
      end
      else
      begin
         in_d1 <= gpio_in_i;
         in_d2 <= in_d1;
         in_d3 <= in_d2;
         in_d4 <= in_d3;
      end
   end

   // --------------------------------------------------
   // reset and combined interrupt
   // --------------------------------------------------
   a_reset_quiet: assert property (@(posedge PCLK)
      (!aresetn || $rose(aresetn)) |-> (int_o == '0 && !int_or_o && gpio_oe_o == '0))
      else begin $error("outputs active around reset"); fail_cnt++; end

   a_int_or: assert property (@(posedge PCLK) int_or_o == |int_o)
      else begin $error("int_or_o differs from OR of int_o"); fail_cnt++; end

   // --------------------------------------------------
   // per-pin checks
   // --------------------------------------------------
   for (genvar i = 0; i < IO_NUM; i++)
   begin : g_chk
      logic [2:0] t;
      logic       in3;
      logic       in4;
      logic       edge_type;
      logic       edge_seen;

      assign t   = cfg[i][CFG_TYPE_LSB +: 3];
      assign in3 = in_d3[i];
      assign in4 = in_d4[i];
      assign edge_type = (t == INT_EDGE_POS) || (t == INT_EDGE_NEG) || (t == INT_EDGE_BOTH);
      // matching edge three edges back, relative to the type field
      assign edge_seen = ((t == INT_EDGE_POS) && in3 && !in4)
                      || ((t == INT_EDGE_NEG) && !in3 && in4)
                      || ((t == INT_EDGE_BOTH) && (in3 != in4));

      a_out: assert property (@(posedge PCLK)
         gpio_out_o[i] == (cfg[i][CFG_OUT_EN] & gpout[i]))
         else begin $error("gpio_out_o[%0d] wrong", i); fail_cnt++; end

      a_oe: assert property (@(posedge PCLK)
         gpio_oe_o[i] == (cfg[i][CFG_OE_EN] & cfg[i][CFG_OUT_EN]))
         else begin $error("gpio_oe_o[%0d] wrong", i); fail_cnt++; end

      a_level: assert property (@(posedge PCLK) disable iff (!aresetn)
         (cfg[i][CFG_INT_EN] && (t == INT_LEVEL_HIGH || t == INT_LEVEL_LOW)
            && $stable(cfg[i]) && $past($stable(cfg[i])) && $past($stable(cfg[i]), 2)
            && $past(aresetn, 4))
         |-> int_o[i] == (in3 ^ (t == INT_LEVEL_LOW)))
         else begin $error("level int_o[%0d] wrong", i); fail_cnt++; end

      a_edge_set: assert property (@(posedge PCLK) disable iff (!aresetn)
         (cfg[i][CFG_INT_EN] && $stable(cfg[i]) && $past(aresetn, 5) && edge_seen)
         |-> int_o[i])
         else begin $error("edge int_o[%0d] not set", i); fail_cnt++; end

      a_edge_hold: assert property (@(posedge PCLK) disable iff (!aresetn)
         (cfg[i][CFG_INT_EN] && edge_type && int_o[i] && !(intr_clr_we && wdata[i]))
         |=> (int_o[i] || $changed(cfg[i])))
         else begin $error("edge int_o[%0d] dropped", i); fail_cnt++; end

      // flags must not survive a disable, so re-enabling starts quiet
      a_disable: assert property (@(posedge PCLK) disable iff (!aresetn)
         ($rose(cfg[i][CFG_INT_EN]) && edge_type) |-> !int_o[i])
         else begin $error("int_o[%0d] stale after re-enable", i); fail_cnt++; end
   end

endmodule

`default_nettype wire

//--- testbench/tb_gpio.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gpio
   import gpio_reg_pkg::*;
;
   localparam int IO_NUM = 8;
   localparam logic [IO_NUM-1:0] RESET_OUT = 8'hA5;
   localparam int MAX_CYCLES = 2000;

   logic              PCLK = 1'b0;
   logic              aresetn;
   logic              psel_i;
   logic              penable_i;
   logic              pwrite_i;
   apb_addr_t         paddr_i;
   apb_data_t         pwdata_i;
   apb_data_t         prdata_o;
   logic              pready_o;
   logic              pslverr_o;
   logic [IO_NUM-1:0] gpio_in_i;
   logic [IO_NUM-1:0] int_o;
   logic              int_or_o;
   logic [IO_NUM-1:0] gpio_out_o;
   logic [IO_NUM-1:0] gpio_oe_o;

   int         seed;
   int         err_cnt;
   int         test_cnt;
   int         errs_at_start;
   int         cycle_cnt;
   logic [7:0] cfg_model [IO_NUM];
   logic [7:0] in_mask;
   logic [7:0] rand_byte;

   gpio_top #(
      .IO_NUM        (IO_NUM),
      .OUT_RESET_VAL (RESET_OUT)
   ) i_dut (.*);

   bind gpio_top gpio_checker #(.IO_NUM(IO_NUM)) i_checker (
      .PCLK(PCLK), .aresetn(aresetn), .gpio_in_i(gpio_in_i), .int_o(int_o),
      .int_or_o(int_or_o), .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o),
      .gpout(gpout), .cfg(cfg), .intr_clr_we(intr_clr_we), .wdata(wdata)
   );

   always #10 PCLK = ~PCLK;

   // run limit
   always @(posedge PCLK)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display("Regression failed");
         $finish;
      end
   end

   // zero wait states and no slave error in the access phase
   task automatic check_bus_response();
      if (pready_o !== 1'b1)
      begin
         $display("** Error at %0t: pready_o expected 1, got %b", $time, pready_o);
         err_cnt++;
      end
      if (pslverr_o !== 1'b0)
      begin
         $display("** Error at %0t: pslverr_o expected 0, got %b", $time, pslverr_o);
         err_cnt++;
      end
   endtask

   // --------------------------------------------------
   // APB transfers, driven on the falling edge
   // --------------------------------------------------
   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      @(negedge PCLK);
      psel_i    = 1'b1;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(negedge PCLK);
      penable_i = 1'b1;
      check_bus_response();
      @(negedge PCLK);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
      @(negedge PCLK);
      psel_i    = 1'b1;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(negedge PCLK);
      penable_i = 1'b1;
      check_bus_response();
      // sampled after the access edge, stable until the next rising edge
      @(negedge PCLK);
      data      = prdata_o;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
      apb_data_t got;
      apb_read(addr, got);
      if (got !== exp)
      begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge PCLK);
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = err_cnt + i_dut.i_checker.fail_cnt - errs_at_start;
      test_cnt++;
      $display("test %0d %s finished with %0d errors", test_cnt, name, errs);
      errs_at_start = err_cnt + i_dut.i_checker.fail_cnt;
   endtask

   task automatic write_cfg(input int pin, input logic [7:0] val);
      cfg_model[pin] = val;
      apb_write(apb_addr_t'(pin * 4), {24'h0, val});
   endtask

   initial
   begin
      seed          = 48103;
      err_cnt       = 0;
      test_cnt      = 0;
      errs_at_start = 0;
      cycle_cnt     = 0;
      aresetn       = 1'b0;
      psel_i        = 1'b0;
      penable_i     = 1'b0;
      pwrite_i      = 1'b0;
      paddr_i       = '0;
      pwdata_i      = '0;
      gpio_in_i     = '0;
      wait_cycles(2);
      aresetn = 1'b1;

      // reset values
      wait_cycles(2);
      read_expect(ADDR_GPOUT, 32'h0000_00A5, "prdata GPOUT");
      report_test("reset");

      // random configuration and output data
      for (int p = 0; p < IO_NUM; p++)
      begin
         rand_byte = 8'($random(seed));
         write_cfg(p, rand_byte);
      end
      for (int p = 0; p < IO_NUM; p++)
         read_expect(apb_addr_t'(p * 4), {24'h0, cfg_model[p]}, "prdata CFG");
      rand_byte = 8'($random(seed));
      apb_write(ADDR_GPOUT, {24'h0, rand_byte});
      read_expect(ADDR_GPOUT, {24'h0, rand_byte}, "prdata GPOUT");
      report_test("config_output");

      // gated input
      for (int k = 0; k < 4; k++)
      begin
         @(negedge PCLK);
         gpio_in_i = 8'($random(seed));
         wait_cycles(4);
         for (int p = 0; p < IO_NUM; p++)
            in_mask[p] = cfg_model[p][1];
         read_expect(ADDR_GPIN, {24'h0, gpio_in_i & in_mask}, "prdata GPIN");
      end
      report_test("input");

      // level interrupts, even pins high, odd pins low
      for (int p = 0; p < IO_NUM; p++)
         write_cfg(p, (p % 2 == 0) ? 8'h0A : 8'h2A);
      for (int k = 0; k < 12; k++)
      begin
         @(negedge PCLK);
         gpio_in_i = 8'($random(seed));
         wait_cycles(k % 4 + 1);
      end
      report_test("level_interrupt");

      // edge interrupts: pin 0 rising, pin 1 falling, pin 2 both
      @(negedge PCLK);
      gpio_in_i = '0;
      write_cfg(0, 8'h48);
      write_cfg(1, 8'h68);
      write_cfg(2, 8'h88);
      for (int p = 3; p < IO_NUM; p++)
         write_cfg(p, 8'hE8);
      wait_cycles(5);
      apb_write(ADDR_INTR, 32'hFF);
      wait_cycles(2);
      read_expect(ADDR_INTR, 32'h0, "prdata INTR");
      gpio_in_i = 8'h07;
      wait_cycles(5);
      gpio_in_i = 8'h00;
      wait_cycles(5);
      read_expect(ADDR_INTR, 32'h07, "prdata INTR");
      apb_write(ADDR_INTR, 32'h07);
      wait_cycles(2);
      read_expect(ADDR_INTR, 32'h0, "prdata INTR");
      report_test("edge_interrupt");

      // OR of interrupts and disable, pin 0 also picks up a rising flag
      write_cfg(3, 8'h0A);
      gpio_in_i = 8'h09;
      wait_cycles(5);
      if (int_or_o !== 1'b1)
      begin
         $display("** Error at %0t: int_or_o expected 1, got %b", $time, int_or_o);
         err_cnt++;
      end
      write_cfg(3, 8'h02);
      if (int_o[3] !== 1'b0)
      begin
         $display("** Error at %0t: int_o[3] expected 0, got %b", $time, int_o[3]);
         err_cnt++;
      end
      // disable and re-enable pin 0 while its flag is set
      write_cfg(0, 8'h40);
      write_cfg(0, 8'h48);
      wait_cycles(3);
      report_test("interrupt_or");

      err_cnt = err_cnt + i_dut.i_checker.fail_cnt;
      $display("%0d tests run, %0d errors", test_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
logic/gpio_reg_pkg.sv
logic/gpio_cfg_pkg.sv
logic/gpio_apb_decode.sv
logic/gpio_pin_slice.sv
logic/gpio_read_mux.sv
logic/gpio_top.sv
testbench/gpio_checker.sv
testbench/tb_gpio.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_gpio
FILELIST   := sources.f
FLAGS      := --binary --assert --timing -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
